// File: Bender.yml
package:
  name: mmu

export_include_dirs:
  - .

sources:
  - mmu_pkg.sv
  - tlbLookup.sv
  - tableWalker.sv
  - faultRecorder.sv
  - mmuTop.sv
  - target: test
    files:
      - mmu_asserts.sv
      - mmuTb.sv

// File: faultRecorder.sv
`timescale 1ns/1ps

module faultRecorder (
  input  logic              clk,
  input  logic              reset,
  input  logic              faultValid,
  input  mmu_pkg::faultInfo fault,
  output logic [7:0]        fsr,
  output logic [31:0]       far
);

  // ====================
  // Fault record
  // ====================

  // Sticky until the next fault, read by the abort handler
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      fsr <= 8'h00;
      far <= 32'h0;
    end else if (faultValid) begin
      // Domain field left at zero
      fsr <= {3'b000, fault.isData, fault.status};
      far <= fault.far;
    end
  end

endmodule

// File: mmuTb.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module mmuTb;

  // Expected answer and fault record for one request
  typedef struct packed {
    mmu_pkg::mmuResp resp;
    logic [7:0]      fsr;
    logic [31:0]     far;
    logic [31:0]     va;
  } expectRec;

  // First-level table at 0x4000
  localparam logic [17:0] TableBase = 18'h00001;

  // ====================
  // DUT signals
  // ====================

  logic             clk;
  logic             reset;
  logic             enable;
  logic [17:0]      tBase;
  logic             reqValid;
  mmu_pkg::mmuReq   req;
  logic             memReady;
  mmu_pkg::pageDesc memRData;
  logic             respDone;
  mmu_pkg::mmuResp  resp;
  logic             memReq;
  mmu_pkg::memRead  memRd;
  logic [7:0]       fsr;
  logic [31:0]      far;

  // 64 KB of page table words
  logic [31:0] mem [16384];

  expectRec    expectQ [$];
  logic [7:0]  expFsr;
  logic [31:0] expFar;
  int          cycleCount;
  int          readCount;
  int          valueErrors;
  int          timeoutErrors;
  logic        aborted;
  logic [31:0] lfsrState;

  mmuTop mmuTop_i (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .tBase    (tBase),
    .reqValid (reqValid),
    .req      (req),
    .memReady (memReady),
    .memRData (memRData),
    .respDone (respDone),
    .resp     (resp),
    .memReq   (memReq),
    .memRd    (memRd),
    .fsr      (fsr),
    .far      (far)
  );

  // 20 ns clock and rising edge count
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin
    cycleCount = 0;
    forever begin
      @(posedge clk);
      cycleCount++;
    end
  end

  // ====================
  // Helpers
  // ====================

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Hash of the full address with kind 00 so stray fetches fault
  function automatic logic [31:0] fillWord(input logic [31:0] addr);
    logic [31:0] h;
    h = addr ^ {addr[18:0], 13'h0} ^ 32'h6d2b_79f5;
    return {h[31:2], 2'b00};
  endfunction

  task automatic loadTables();
    for (int i = 0; i < 16384; i++) begin
      mem[i] = fillWord(32'(i) << 2);
    end
    // L1 entries 1 to 4 hold section, coarse at 0x8000, fine at 0x9000 and fault
    mem[{TableBase, 12'h001}] = 32'h1230_0002;
    mem[{TableBase, 12'h002}] = 32'h0000_8001;
    mem[{TableBase, 12'h003}] = 32'h0000_9003;
    mem[{TableBase, 12'h004}] = 32'hdead_bee0;
    // Coarse table with large, small and fault entries
    mem[14'h2000] = 32'habcd_0001;
    mem[14'h2001] = 32'h5566_7002;
    mem[14'h2002] = 32'h1357_9bd0;
    // Fine table with large, small, tiny and fault entries
    mem[14'h2400] = 32'h7788_0001;
    mem[14'h2401] = 32'h3344_5002;
    mem[14'h2402] = 32'h9abc_dc03;
    mem[14'h2403] = 32'h2468_ace0;
  endtask

  // Expected answer from the two-level walk rules
  function automatic mmu_pkg::mmuResp refTranslate(
    input logic [31:0] va,
    input logic        isData,
    input logic        en,
    output logic [7:0] fsrOut,
    output int         reads
  );
    mmu_pkg::mmuResp r;
    logic [31:0]     d1;
    logic [31:0]     d2;
    logic [31:0]     l2Addr;
    r.pa = va;
    r.fault = 1'b0;
    fsrOut = 8'h00;
    reads = 0;
    if (en) begin
      reads = 1;
      d1 = mem[{tBase, va[31:20]}];
      if (d1[1:0] == 2'b00) begin
        r = '{pa: 32'h0, fault: 1'b1};
        fsrOut = {3'b000, isData, `MMU_FSR_SECTION};
      end else if (d1[1:0] == 2'b10) begin
        r.pa = {d1[31:20], va[19:0]};
      end else begin
        reads = 2;
        // Coarse indexes 4 KB slots and fine indexes 1 KB slots
        l2Addr = (d1[1:0] == 2'b01) ? {d1[31:10], va[19:12], 2'b00}
                                    : {d1[31:12], va[19:10], 2'b00};
        d2 = mem[l2Addr[15:2]];
        case (d2[1:0])
          2'b00: begin
            r = '{pa: 32'h0, fault: 1'b1};
            fsrOut = {3'b000, isData, `MMU_FSR_PAGE};
          end
          2'b01:   r.pa = {d2[31:16], va[15:0]};
          2'b10:   r.pa = {d2[31:12], va[11:0]};
          default: r.pa = {d2[31:10], va[9:0]};
        endcase
      end
    end
    return r;
  endfunction

  // ====================
  // Compare tasks
  // ====================

  task automatic checkResp(input mmu_pkg::mmuResp got, input mmu_pkg::mmuResp exp,
                           input logic [31:0] va);
    if (got !== exp) begin
      $display("FAIL %0t: va %h gave pa %h fault %b, expected pa %h fault %b",
               $time, va, got.pa, got.fault, exp.pa, exp.fault);
      valueErrors++;
    end
  endtask

  task automatic checkFault(input logic [7:0] gotFsr, input logic [31:0] gotFar,
                            input logic [7:0] wantFsr, input logic [31:0] wantFar);
    if (gotFsr !== wantFsr || gotFar !== wantFar) begin
      $display("FAIL %0t: fsr %h far %h, expected fsr %h far %h",
               $time, gotFsr, gotFar, wantFsr, wantFar);
      valueErrors++;
    end
  endtask

  task automatic checkCount(input string what, input logic [31:0] va,
                            input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %0t: va %h %s %0d, expected %0d", $time, va, what, got, exp);
      valueErrors++;
    end
  endtask

  // ====================
  // Memory model and compare
  // ====================

  // 0 to 3 wait cycles per read from two LFSR bits
  initial begin : memoryModel
    int   waitLeft;
    logic serving;
    waitLeft = 0;
    serving = 1'b0;
    memReady = 1'b0;
    memRData = '0;
    readCount = 0;
    lfsrState = 32'hb3b5_a5b1;
    forever begin
      @(negedge clk);
      memReady = 1'b0;
      if (!reset && memReq) begin
        if (!serving) begin
          serving = 1'b1;
          readCount++;
          lfsrState = lfsrNext(lfsrState);
          waitLeft = lfsrState[0];
          lfsrState = lfsrNext(lfsrState);
          waitLeft = waitLeft * 2 + lfsrState[0];
        end
        if (waitLeft == 0) begin
          memReady = 1'b1;
          memRData = mem[memRd.addr[15:2]];
          serving = 1'b0;
        end else begin
          waitLeft--;
        end
      end
    end
  end

  initial begin : compareProc
    expectRec rec;
    forever begin
      @(negedge clk);
      if (!reset && respDone) begin
        if (expectQ.size() == 0) begin
          $display("Unexpected respDone with no request outstanding at %0t", $time);
          valueErrors++;
        end else begin
          rec = expectQ.pop_front();
          checkResp(resp, rec.resp, rec.va);
          checkFault(fsr, far, rec.fsr, rec.far);
        end
      end
    end
  end

  // ====================
  // Stimulus
  // ====================

  // One request issued on a falling edge
  task automatic translate(input logic [31:0] va, input logic isData, input logic expectHit);
    expectRec        rec;
    mmu_pkg::mmuResp expResp;
    logic [7:0]      walkFsr;
    int              expReads;
    int              startReads;
    int              sampleCycle;
    int              n;
    logic            timedOut;
    if (!aborted) begin
      expResp = refTranslate(va, isData, enable, walkFsr, expReads);
      if (expectHit) begin
        expReads = 0;
      end
      // Record changes on faults only
      if (expResp.fault) begin
        expFsr = walkFsr;
        expFar = va;
      end
      rec = '{resp: expResp, fsr: expFsr, far: expFar, va: va};
      expectQ.push_back(rec);
      startReads = readCount;
      req = '{va: va, isData: isData};
      reqValid = 1'b1;
      sampleCycle = cycleCount + 1;
      timedOut = 1'b0;
      n = 0;
      if (!expectHit) begin
        while (!memReq && n < `MMU_WALK_TIMEOUT) begin
          @(negedge clk);
          n++;
        end
        timedOut = !memReq;
        if (timedOut) begin
          $display("Timeout: no memory read started for va %h", va);
        end
      end
      n = 0;
      while (!timedOut && !respDone && n < `MMU_WALK_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!timedOut && !respDone) begin
        $display("Timeout: no respDone for va %h", va);
        timedOut = 1'b1;
      end
      if (timedOut) begin
        timeoutErrors++;
        aborted = 1'b1;
      end else begin
        if (expectHit) begin
          checkCount("latency", va, cycleCount - sampleCycle, 2);
        end
        checkCount("memory reads", va, readCount - startReads, expReads);
        // Drop after respDone and idle one cycle before the next request
        reqValid = 1'b0;
        @(negedge clk);
      end
    end
  endtask

  // Disable flushes the TLB
  task automatic toggleEnable();
    if (!aborted) begin
      enable = 1'b0;
      repeat (2) @(negedge clk);
      enable = 1'b1;
      @(negedge clk);
    end
  endtask

  initial begin : stimulus
    int k;
    reset = 1'b1;
    enable = 1'b0;
    tBase = TableBase;
    reqValid = 1'b0;
    req = '0;
    expFsr = 8'h00;
    expFar = 32'h0;
    valueErrors = 0;
    timeoutErrors = 0;
    aborted = 1'b0;
    loadTables();
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // Flat mapping ignores the fault entry
    translate(32'h1234_5678, 1'b0, 1'b1);
    translate(32'h0045_6789, 1'b1, 1'b1);
    enable = 1'b1;
    @(negedge clk);

    // Sections then coarse and fine pages
    translate(32'h0012_3456, 1'b0, 1'b0);
    translate(32'h001f_fffc, 1'b1, 1'b0);
    translate(32'h0020_0abc, 1'b0, 1'b0);
    translate(32'h0020_1def, 1'b1, 1'b0);
    translate(32'h0030_0123, 1'b0, 1'b0);
    translate(32'h0030_0567, 1'b0, 1'b0);
    translate(32'h0030_09ab, 1'b1, 1'b0);

    // Same 1 KB pages hit
    translate(32'h0012_37fc, 1'b0, 1'b1);
    translate(32'h0030_09f0, 1'b1, 1'b1);
    translate(32'h0020_1c40, 1'b0, 1'b1);

    // L1 fault and a hit, then L2 faults and a good walk
    translate(32'h0045_6789, 1'b1, 1'b0);
    translate(32'h0012_3500, 1'b0, 1'b1);
    translate(32'h0020_2468, 1'b0, 1'b0);
    translate(32'h0030_0c10, 1'b1, 1'b0);
    translate(32'h0012_5000, 1'b0, 1'b0);

    // One page more than the TLB holds evicts the first one
    toggleEnable();
    for (k = 0; k <= `MMU_TLB_ENTRIES; k++) begin
      translate(32'h0010_0000 + 32'(k) * 32'h400, 1'b0, 1'b0);
    end
    translate(32'h0010_0010 + 32'(`MMU_TLB_ENTRIES) * 32'h400, 1'b0, 1'b1);
    translate(32'h0010_0404, 1'b1, 1'b1);
    translate(32'h0010_0008, 1'b0, 1'b0);
    toggleEnable();
    translate(32'h0010_0020 + 32'(`MMU_TLB_ENTRIES) * 32'h400, 1'b0, 1'b0);

    if (!aborted && expectQ.size() != 0) begin
      $display("Requests left without an answer: %0d", expectQ.size());
      valueErrors++;
    end
    $display("Errors: %0d value, %0d timeout, %0d assertion",
             valueErrors, timeoutErrors, mmuTop_i.mmuAsserts_i.assertFails);
    if (valueErrors == 0 && timeoutErrors == 0 &&
        mmuTop_i.mmuAsserts_i.assertFails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: mmuTop.sv
`timescale 1ns/1ps

module mmuTop (
  input  logic             clk,
  input  logic             reset,
  input  logic             enable,
  input  logic [17:0]      tBase,
  input  logic             reqValid,
  input  mmu_pkg::mmuReq   req,
  input  logic             memReady,
  input  mmu_pkg::pageDesc memRData,
  output logic             respDone,
  output mmu_pkg::mmuResp  resp,
  output logic             memReq,
  output mmu_pkg::memRead  memRd,
  output logic [7:0]       fsr,
  output logic [31:0]      far
);

  // Lookup to walker
  logic              missValid;
  mmu_pkg::mmuReq    missReq;

  // Walker back to lookup
  logic              fillValid;
  mmu_pkg::tlbFill   fill;
  logic              walkDone;
  mmu_pkg::mmuResp   walkResp;

  // Walker to fault registers
  logic              faultValid;
  mmu_pkg::faultInfo fault;

  // ====================
  // Stage chain
  // ====================

  tlbLookup tlbLookup_i (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .reqValid  (reqValid),
    .req       (req),
    .fillValid (fillValid),
    .fill      (fill),
    .walkDone  (walkDone),
    .walkResp  (walkResp),
    .missValid (missValid),
    .missReq   (missReq),
    .respDone  (respDone),
    .resp      (resp)
  );

  tableWalker tableWalker_i (
    .clk        (clk),
    .reset      (reset),
    .tBase      (tBase),
    .missValid  (missValid),
    .missReq    (missReq),
    .memReady   (memReady),
    .memRData   (memRData),
    .memReq     (memReq),
    .memRd      (memRd),
    .fillValid  (fillValid),
    .fill       (fill),
    .faultValid (faultValid),
    .fault      (fault),
    .walkDone   (walkDone),
    .walkResp   (walkResp)
  );

  // Record side, no effect on the answer path
  faultRecorder faultRecorder_i (
    .clk        (clk),
    .reset      (reset),
    .faultValid (faultValid),
    .fault      (fault),
    .fsr        (fsr),
    .far        (far)
  );

endmodule

// File: mmu_asserts.sv
`timescale 1ns/1ps

module mmuAsserts (
  input logic            clk,
  input logic            reset,
  input logic            memReq,
  input logic            memReady,
  input mmu_pkg::memRead memRd,
  input logic            respDone
);

  // Failed assertion count
  int assertFails = 0;

  // ====================
  // Memory port
  // ====================

  // Address held until memReady
  memRdStable: assert property (
    @(posedge clk) disable iff (reset)
    (memReq && !memReady) |=> $stable(memRd)
  ) else begin
    $error("memRd changed while a read was waiting for memReady");
    assertFails++;
  end

  // ====================
  // Core side
  // ====================

  respDonePulse: assert property (
    @(posedge clk) disable iff (reset)
    respDone |=> !respDone
  ) else begin
    $error("respDone stayed high for more than one cycle");
    assertFails++;
  end

  // Quiet outputs throughout reset
  resetQuiet: assert property (
    @(negedge clk) reset |-> (!memReq && !respDone)
  ) else begin
    $error("memReq or respDone high during reset");
    assertFails++;
  end

endmodule

bind mmuTop mmuAsserts mmuAsserts_i (
  .clk      (clk),
  .reset    (reset),
  .memReq   (memReq),
  .memReady (memReady),
  .memRd    (memRd),
  .respDone (respDone)
);

// File: mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// ====================
// TLB sizing
// ====================

// Fully associative entries, round-robin refill
`define MMU_TLB_ENTRIES 8

// Upper bound in cycles for one translation, memory waits included
`define MMU_WALK_TIMEOUT 200

// ====================
// Fault status codes
// ====================

// Translation fault on the first-level descriptor
`define MMU_FSR_SECTION 4'b0101
// Translation fault on the second-level descriptor
`define MMU_FSR_PAGE 4'b0111

// ====================
// Descriptor kind field
// ====================

// First level: 01 coarse, 10 section, 11 fine
// Second level: 01 large, 10 small, 11 tiny
`define MMU_KIND_FAULT 2'b00
`define MMU_KIND_COARSE 2'b01
`define MMU_KIND_SECTION 2'b10
`define MMU_KIND_FINE 2'b11
`define MMU_KIND_LARGE 2'b01
`define MMU_KIND_SMALL 2'b10
`define MMU_KIND_TINY 2'b11

`endif

// File: mmu_pkg.sv
package mmu_pkg;

  // ====================
  // Core and memory side
  // ====================

  // Translation request from the core
  typedef struct packed {
    logic [31:0] va;
    // Data access, else instruction fetch
    logic        isData;
  } mmuReq;

  // Translation answer, pa is zero on a fault
  typedef struct packed {
    logic [31:0] pa;
    logic        fault;
  } mmuResp;

  // TLB write at 1 KB granularity
  typedef struct packed {
    logic [21:0] vpn;
    logic [21:0] ppn;
  } tlbFill;

  // Descriptor read address
  typedef struct packed {
    logic [31:0] addr;
  } memRead;

  // Fault record for the status and address registers
  typedef struct packed {
    logic [3:0]  status;
    logic        isData;
    logic [31:0] far;
  } faultInfo;

  // ====================
  // Descriptor views
  // ====================

  // Section base in base[21:10], coarse in base, fine in base[21:2]
  typedef struct packed {
    logic [21:0] base;
    logic [7:0]  middle;
    logic [1:0]  kind;
  } firstLevelDesc;

  // Large base in base[19:4], small in base, tiny adds middle[9:8]
  typedef struct packed {
    logic [19:0] base;
    logic [9:0]  middle;
    logic [1:0]  kind;
  } secondLevelDesc;

  // One fetched word, decoded by table level
  typedef union packed {
    firstLevelDesc  firstLevel;
    secondLevelDesc secondLevel;
  } pageDesc;

  // Table walk FSM
  typedef enum logic [2:0] {
    idle,
    firstFetch,
    secondFetch,
    fill,
    faultOut
  } walkState;

endpackage

// File: tableWalker.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tableWalker (
  input  logic              clk,
  input  logic              reset,
  input  logic [17:0]       tBase,
  input  logic              missValid,
  input  mmu_pkg::mmuReq    missReq,
  input  logic              memReady,
  input  mmu_pkg::pageDesc  memRData,
  output logic              memReq,
  output mmu_pkg::memRead   memRd,
  output logic              fillValid,
  output mmu_pkg::tlbFill   fill,
  output logic              faultValid,
  output mmu_pkg::faultInfo fault,
  output logic              walkDone,
  output mmu_pkg::mmuResp   walkResp
);

  mmu_pkg::walkState state;
  mmu_pkg::walkState nextState;

  // Walk context
  mmu_pkg::mmuReq  reqQ;
  mmu_pkg::pageDesc firstDesc;
  logic [21:0]      ppnQ;
  logic [3:0]       statusQ;

  // ====================
  // FSM
  // ====================

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= mmu_pkg::idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      mmu_pkg::idle: begin
        if (missValid) begin
          nextState = mmu_pkg::firstFetch;
        end
      end
      mmu_pkg::firstFetch: begin
        if (memReady) begin
          case (memRData.firstLevel.kind)
            `MMU_KIND_FAULT:   nextState = mmu_pkg::faultOut;
            `MMU_KIND_SECTION: nextState = mmu_pkg::fill;
            // Coarse or fine pointer
            default:           nextState = mmu_pkg::secondFetch;
          endcase
        end
      end
      mmu_pkg::secondFetch: begin
        if (memReady) begin
          if (memRData.secondLevel.kind == `MMU_KIND_FAULT) begin
            nextState = mmu_pkg::faultOut;
          end else begin
            nextState = mmu_pkg::fill;
          end
        end
      end
      // Single cycle each, back to idle
      mmu_pkg::fill:     nextState = mmu_pkg::idle;
      mmu_pkg::faultOut: nextState = mmu_pkg::idle;
      default:           nextState = mmu_pkg::idle;
    endcase
  end

  // ====================
  // Walk context
  // ====================

  always_ff @(posedge clk) begin
    if (state == mmu_pkg::idle && missValid) begin
      reqQ <= missReq;
    end
    if (state == mmu_pkg::firstFetch && memReady) begin
      firstDesc <= memRData;
      statusQ   <= `MMU_FSR_SECTION;
      // Section maps 1 MB
      ppnQ <= {memRData.firstLevel.base[21:10], reqQ.va[19:10]};
    end
    if (state == mmu_pkg::secondFetch && memReady) begin
      statusQ <= `MMU_FSR_PAGE;
      case (memRData.secondLevel.kind)
        // 64 KB page
        `MMU_KIND_LARGE: ppnQ <= {memRData.secondLevel.base[19:4], reqQ.va[15:10]};
        // 4 KB page
        `MMU_KIND_SMALL: ppnQ <= {memRData.secondLevel.base, reqQ.va[11:10]};
        // 1 KB page, base reaches into the middle field
        default: ppnQ <= {memRData.secondLevel.base, memRData.secondLevel.middle[9:8]};
      endcase
    end
  end

  // ====================
  // Memory port
  // ====================

  // Held across both fetches, address fixed within a fetch
  assign memReq = (state == mmu_pkg::firstFetch) || (state == mmu_pkg::secondFetch);

  always_comb begin
    if (state == mmu_pkg::secondFetch) begin
      if (firstDesc.firstLevel.kind == `MMU_KIND_COARSE) begin
        // Coarse table has 256 entries
        memRd.addr = {firstDesc.firstLevel.base, reqQ.va[19:12], 2'b00};
      end else begin
        // Fine table has 1024 entries
        memRd.addr = {firstDesc.firstLevel.base[21:2], reqQ.va[19:10], 2'b00};
      end
    end else begin
      // First-level index
      memRd.addr = {tBase, reqQ.va[31:20], 2'b00};
    end
  end

  // ====================
  // Results
  // ====================

  assign fillValid  = (state == mmu_pkg::fill);
  assign faultValid = (state == mmu_pkg::faultOut);
  assign walkDone   = fillValid || faultValid;

  assign fill.vpn = reqQ.va[31:10];
  assign fill.ppn = ppnQ;

  assign fault.status = statusQ;
  assign fault.isData = reqQ.isData;
  assign fault.far    = reqQ.va;

  // Faulted walk returns a zero PA
  assign walkResp.pa    = faultValid ? 32'h0 : {ppnQ, reqQ.va[9:0]};
  assign walkResp.fault = faultValid;

endmodule

// File: tlbLookup.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlbLookup (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  logic            reqValid,
  input  mmu_pkg::mmuReq  req,
  input  logic            fillValid,
  input  mmu_pkg::tlbFill fill,
  input  logic            walkDone,
  input  mmu_pkg::mmuResp walkResp,
  output logic            missValid,
  output mmu_pkg::mmuReq  missReq,
  output logic            respDone,
  output mmu_pkg::mmuResp resp
);

  localparam int PtrBits = $clog2(`MMU_TLB_ENTRIES);

  // Pipeline flags, one translation in flight
  logic            busy;
  logic            lookValid;
  logic            answerValid;
  logic            answerHit;
  mmu_pkg::mmuResp answerResp;

  // TLB storage
  logic [`MMU_TLB_ENTRIES-1:0] entryValid;
  logic [21:0]                 entryVpn [`MMU_TLB_ENTRIES];
  logic [21:0]                 entryPpn [`MMU_TLB_ENTRIES];
  logic [PtrBits-1:0]          fillPtr;

  // Compare results
  logic [`MMU_TLB_ENTRIES-1:0] hitVec;
  logic                        hitAny;
  logic [21:0]                 hitPpn;

  // ====================
  // Request pipeline
  // ====================

  // Sample, compare, then answer or hand off to the walker
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      busy        <= 1'b0;
      lookValid   <= 1'b0;
      answerValid <= 1'b0;
      missValid   <= 1'b0;
      respDone    <= 1'b0;
    end else begin
      lookValid   <= reqValid && !busy;
      answerValid <= lookValid;
      missValid   <= answerValid && !answerHit;
      respDone    <= (answerValid && answerHit) || walkDone;
      // Held request is ignored until its answer goes out
      if (reqValid && !busy) begin
        busy <= 1'b1;
      end else if (respDone) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid && !busy) begin
      missReq <= req;
    end
    if (lookValid) begin
      // Disabled MMU answers with a flat mapping
      answerHit       <= !enable || hitAny;
      answerResp.pa   <= enable ? {hitPpn, missReq.va[9:0]} : missReq.va;
      answerResp.fault <= 1'b0;
    end
    if (walkDone) begin
      resp <= walkResp;
    end else if (answerValid && answerHit) begin
      resp <= answerResp;
    end
  end

  // ====================
  // TLB array
  // ====================

  // Tags are unique, so OR of matching entries gives the hit PPN
  always_comb begin
    hitPpn = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      hitVec[i] = entryValid[i] && (entryVpn[i] == missReq.va[31:10]);
      if (hitVec[i]) begin
        hitPpn = hitPpn | entryPpn[i];
      end
    end
  end

  assign hitAny = |hitVec;

  // Valid bits, flushed while disabled
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      entryValid <= '0;
      fillPtr    <= '0;
    end else if (!enable) begin
      entryValid <= '0;
    end else if (fillValid) begin
      entryValid[fillPtr] <= 1'b1;
      // Round-robin victim
      fillPtr <= (fillPtr == PtrBits'(`MMU_TLB_ENTRIES - 1)) ? '0 : fillPtr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillValid) begin
      entryVpn[fillPtr] <= fill.vpn;
      entryPpn[fillPtr] <= fill.ppn;
    end
  end

endmodule

// File: vlog.f
+incdir+.
mmu_pkg.sv
tlbLookup.sv
tableWalker.sv
faultRecorder.sv
mmuTop.sv
mmu_asserts.sv
mmuTb.sv
